//--- bench/statusChecker.sv
`timescale 1ns/100ps

module statusChecker (
  input  logic         clk,
  input  logic         reset,
  input  logic [2:0]   phase,        // Test the bench is driving
  input  logic         advance,
  input  psrPkg::condT condCode,
  input  logic [3:0]   flagsNext,
  input  logic         flagsWrite,
  input  logic         coprocFlags,
  input  logic [4:0]   msrMask,
  input  logic [31:0]  operand,
  input  logic         restore,
  input  logic [5:0]   exceptions,
  input  logic [31:0]  cpsr,
  input  logic [31:0]  spsr,
  input  logic         condPass,
  input  logic         vectorTaken,
  input  logic [31:0]  vectorAddr,
  output int           checkCount,
  output int           errorCount
);
  import psrPkg::*;

  logic [31:0]      modelCpsr;
  logic [4:0][31:0] modelBank;          // svc abt und irq fiq
  logic [31:0]      nextCpsr;
  logic [4:0][31:0] nextBank;
  logic             modelLive = 1'b0;   // Valid once reset was seen
  int               expIdx;

  function automatic string phaseName(input logic [2:0] p);
    case (p)
      3'd0:    return "reset";
      3'd1:    return "condition";
      3'd2:    return "exception";
      3'd3:    return "msr";
      3'd4:    return "restore";
      3'd5:    return "hold";
      default: return "random";
    endcase
  endfunction

  function automatic logic legal(input logic [4:0] m);
    return m == modeUsr || m == modeFiq || m == modeIrq || m == modeSvc ||
           m == modeAbt || m == modeUnd || m == modeSys;
  endfunction

  // Only the exception modes bank an SPSR
  function automatic logic banked(input logic [4:0] m);
    return m != modeUsr && m != modeSys;
  endfunction

  function automatic logic [2:0] slot(input logic [4:0] m);
    case (m)
      modeAbt: return 3'd1;
      modeUnd: return 3'd2;
      modeIrq: return 3'd3;
      modeFiq: return 3'd4;
      default: return 3'd0;
    endcase
  endfunction

  function automatic logic [31:0] spsrView(input logic [31:0] psr, input logic [4:0][31:0] bank);
    return banked(psr[4:0]) ? bank[slot(psr[4:0])] : psr;
  endfunction

  // Code pairs share a base test and the odd code inverts it
  function automatic logic condHolds(input logic [3:0] c, input logic [3:0] f);
    logic n;
    logic z;
    logic cf;
    logic v;
    logic base;
    {n, z, cf, v} = f;
    case (c[3:1])
      3'd0:    base = z;
      3'd1:    base = cf;
      3'd2:    base = n;
      3'd3:    base = v;
      3'd4:    base = cf && !z;
      3'd5:    base = (n == v);
      3'd6:    base = !z && (n == v);
      default: base = 1'b1;             // AL passes so NV never does
    endcase
    return c[0] ? !base : base;
  endfunction

  // 0 none, 1 dabt, 2 fiq, 3 irq, 4 pabt, 5 und, 6 swi
  function automatic int pickException(input logic [5:0] req, input logic [31:0] psr);
    logic [4:0] m;
    m = psr[4:0];
    if (req[2] && m != modeAbt) return 1;
    if (req[0] && !psr[6] && m != modeFiq) return 2;
    if (req[1] && !psr[7] && m != modeIrq) return 3;
    if (req[3] && m != modeAbt) return 4;
    if (req[5] && m != modeUnd) return 5;
    if (req[4] && m != modeSvc) return 6;
    return 0;
  endfunction

  function automatic logic [4:0] excTarget(input int idx);
    case (idx)
      1, 4:    return modeAbt;
      2:       return modeFiq;
      3:       return modeIrq;
      5:       return modeUnd;
      default: return modeSvc;
    endcase
  endfunction

  function automatic logic [31:0] excVector(input int idx);
    case (idx)
      1:       return 32'h10;
      2:       return 32'h1C;
      3:       return 32'h18;
      4:       return 32'h0C;
      5:       return 32'h04;
      default: return 32'h08;
    endcase
  endfunction

  // Expected registers after the edge
  function automatic void referenceStep(
    input  logic [31:0]      psr,
    input  logic [4:0][31:0] bank,
    input  int               idx,
    output logic [31:0]      psrOut,
    output logic [4:0][31:0] bankOut
  );
    logic [31:0] target;
    logic [31:0] merged;
    logic [31:0] saved;
    logic        priv;
    logic        ok;
    psrOut  = psr;
    bankOut = bank;
    ok      = condHolds(condCode, psr[31:28]);
    priv    = psr[4:0] != modeUsr;
    saved   = spsrView(psr, bank);
    target  = msrMask[4] ? saved : psr;
    merged  = target;
    if (msrMask[3]) merged[31:24] = operand[31:24];   // Flags open to all
    if (msrMask[2] && priv) merged[23:16] = operand[23:16];
    if (msrMask[1] && priv) merged[15:8] = operand[15:8];
    if (msrMask[0] && priv) begin
      merged[7:5] = operand[7:5];
      merged[4:0] = legal(operand[4:0]) ? operand[4:0] : target[4:0];
    end
    if (advance) begin
      if (idx != 0) begin
        bankOut[slot(excTarget(idx))] = psr;
        psrOut        = '0;
        psrOut[31:28] = psr[31:28];
        psrOut[7]     = 1'b1;
        psrOut[6]     = (idx == 2);          // F only on FIQ entry
        psrOut[4:0]   = excTarget(idx);
      end else if (ok && |msrMask[3:0] && (!msrMask[4] || banked(psr[4:0]))) begin
        if (msrMask[4]) bankOut[slot(psr[4:0])] = merged;
        else psrOut = merged;
      end else if (ok && restore) begin
        if (banked(psr[4:0]) && legal(saved[4:0])) psrOut = saved;
      end else if (ok && flagsWrite) begin
        psrOut[31:28] = coprocFlags ? operand[31:28] : flagsNext;
      end
    end
  endfunction

  task automatic compare(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("ERR %s %s: expected %h, actual %h", phaseName(phase), what, expected, actual);
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      modelCpsr  = 32'h0000_00D3;       // svc with I and F set
      modelBank  = '0;
      modelLive  = 1'b1;
      checkCount = 0;
      errorCount = 0;
    end else if (modelLive) begin
      expIdx = pickException(exceptions, modelCpsr);
      compare("cpsr", modelCpsr, cpsr);
      compare("spsr", spsrView(modelCpsr, modelBank), spsr);
      compare("condPass", 32'(condHolds(condCode, modelCpsr[31:28])), 32'(condPass));
      compare("vectorTaken", 32'(expIdx != 0), 32'(vectorTaken));
      if (expIdx != 0) compare("vectorAddr", excVector(expIdx), vectorAddr);
      referenceStep(modelCpsr, modelBank, expIdx, nextCpsr, nextBank);
      modelCpsr = nextCpsr;
      modelBank = nextBank;
    end
  end

endmodule

//--- bench/statusUnitTb.sv
`timescale 1ns/100ps

module statusUnitTb;
  import psrPkg::*;

  localparam int directedOps = 256;  // Budget for the directed section
  localparam int randomOps   = 2000;
  localparam int clkPeriod   = 40;
  localparam int timeoutNs   = (directedOps + randomOps + 20) * clkPeriod * 2;

  logic        clk;
  logic        reset;
  logic        advance;
  condT        condCode;
  logic [3:0]  flagsNext;
  logic        flagsWrite;
  logic        coprocFlags;
  logic [4:0]  msrMask;
  logic [31:0] operand;
  logic        restore;
  logic [5:0]  exceptions;
  logic [31:0] cpsr;
  logic [31:0] spsr;
  logic        condPass;
  logic        vectorTaken;
  logic [31:0] vectorAddr;
  logic [2:0]  phase;
  int          checkCount;
  int          errorCount;
  int          seed;
  int          opCount;
  int          holdLen;
  logic [31:0] rnd;

  statusUnit DUT (.*);
  statusChecker uChecker (.*);

  always #(clkPeriod / 2) clk = ~clk;

  // Neutral op that commits nothing
  task automatic clearInputs();
    advance     = 1'b1;
    condCode    = condAl;
    flagsNext   = 4'h0;
    flagsWrite  = 1'b0;
    coprocFlags = 1'b0;
    msrMask     = 5'b00000;
    operand     = 32'h0;
    restore     = 1'b0;
    exceptions  = 6'b000000;
  endtask

  task automatic nextOp();
    @(negedge clk);
    clearInputs();
    opCount++;
  endtask

  task automatic raise(input logic [5:0] req);
    nextOp();
    exceptions = req;
  endtask

  task automatic writeMsr(input logic [4:0] mask, input logic [31:0] value);
    nextOp();
    msrMask = mask;
    operand = value;
  endtask

  task automatic doRestore(input condT cond);
    nextOp();
    restore  = 1'b1;
    condCode = cond;
  endtask

  task automatic randomOp();
    nextOp();
    rnd         = $random(seed);
    advance     = rnd[2:0] != 3'd0;
    condCode    = condT'(rnd[6:3]);
    flagsNext   = rnd[10:7];
    flagsWrite  = rnd[11];
    coprocFlags = rnd[12];
    msrMask     = rnd[17:13];
    restore     = rnd[19:18] == 2'd0;
    exceptions  = rnd[23:20] == 4'd0 ? rnd[29:24] : 6'd0; // About one op in 16
    operand     = $random(seed);
  endtask

  initial begin
    seed    = 10576;
    clk     = 1'b0;
    reset   = 1'b1;
    phase   = 3'd0;
    opCount = 0;
    clearInputs();
    advance = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (2) nextOp();
    phase = 3'd1;
    for (int code = 0; code < 16; code++) begin
      for (int k = 0; k < 4; k++) begin
        nextOp();                        // Load fresh flags
        rnd        = $random(seed);
        flagsWrite = 1'b1;
        flagsNext  = rnd[3:0];
        nextOp();                        // Flag write under test code
        condCode    = condT'(code[3:0]);
        flagsWrite  = 1'b1;
        flagsNext   = rnd[7:4];
        coprocFlags = k[0];
        operand     = $random(seed);
      end
    end
    phase = 3'd2;
    raise(6'b010011);                    // IRQ and FIQ masked and SWI already in svc
    writeMsr(5'b00001, 32'h13);          // Unmask I and F
    raise(6'b000011);                    // FIQ beats IRQ
    doRestore(condAl);
    raise(6'b111111);
    raise(6'b111111);                    // FIQ next from abt
    raise(6'b111100);
    raise(6'b101000);                    // Prefetch blocked in abt
    raise(6'b010000);
    repeat (8) begin
      nextOp();
      rnd        = $random(seed);
      exceptions = rnd[5:0];
      condCode   = condT'(rnd[9:6]);
    end
    raise(6'b010000);                    // Back to svc
    phase = 3'd3;
    writeMsr(5'b01000, 32'hA000_0000);
    writeMsr(5'b00110, 32'h00AB_CD00);
    writeMsr(5'b00001, 32'h0000_0005);   // Illegal mode
    writeMsr(5'b11111, 32'h5A5A_5A17);
    writeMsr(5'b10001, 32'h0000_00C8);
    writeMsr(5'b00001, 32'h0000_0010);   // Drop to usr
    writeMsr(5'b00001, 32'h0000_00DF);
    writeMsr(5'b01111, 32'h3000_00DF);
    writeMsr(5'b11000, 32'hF000_0000);   // No SPSR in usr
    raise(6'b010000);
    writeMsr(5'b00001, 32'h0000_001F);
    writeMsr(5'b11111, 32'hFFFF_FFFF);
    phase = 3'd4;
    doRestore(condAl);                   // sys has no SPSR
    raise(6'b100000);
    doRestore(condNv);
    doRestore(condAl);
    raise(6'b000100);
    writeMsr(5'b01000, 32'h9000_0000);
    doRestore(condAl);
    phase = 3'd5;
    repeat (4) begin
      rnd     = $random(seed);
      holdLen = 1 + int'(rnd[3:0]);
      repeat (holdLen) begin
        randomOp();
        advance = 1'b0;
      end
      randomOp();
    end
    phase = 3'd6;
    repeat (randomOps) randomOp();
    nextOp();
    advance = 1'b0;
    repeat (2) @(negedge clk);
    if (checkCount == 0) $display("No comparisons were made against the reference");
    $display("Checks %0d, errors %0d, ops %0d", checkCount, errorCount, opCount);
    if (errorCount == 0 && checkCount > 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    #(timeoutNs);
    $display("Run timed out after %0d ns before the stimulus finished", timeoutNs);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- rtl/condEval.sv
`timescale 1ns/100ps

module condEval (
  input  psrPkg::condT cond,  // Condition field of the retiring op
  input  logic [3:0]   flags, // N Z C V, as in CPSR[31:28]
  output logic         pass
);
  import psrPkg::*;

  logic n;
  logic z;
  logic c;
  logic v;

  // Offsets relative to the flag nibble
  assign n = flags[bitN - bitV];
  assign z = flags[bitZ - bitV];
  assign c = flags[bitC - bitV];
  assign v = flags[bitV - bitV];

  always_comb begin
    case (cond)
      condEq: pass = z;
      condNe: pass = !z;
      condCs: pass = c;          // Unsigned higher or same
      condCc: pass = !c;
      condMi: pass = n;
      condPl: pass = !n;
      condVs: pass = v;
      condVc: pass = !v;
      condHi: pass = c && !z;    // Unsigned higher
      condLs: pass = !c || z;
      // Signed compares from N xor V
      condGe: pass = (n == v);
      condLt: pass = (n != v);
      condGt: pass = !z && (n == v);
      condLe: pass = z || (n != v);
      condAl: pass = 1'b1;
      condNv: pass = 1'b0;       // Never code
      default: pass = 1'b0;
    endcase
  end

endmodule

//--- rtl/exceptionPrioritizer.sv
`timescale 1ns/100ps

module exceptionPrioritizer (
  input  logic [5:0]                  exceptions, // undef swi pabt dabt irq fiq
  input  logic [psrPkg::psrWidth-1:0] cpsr,
  output psrPkg::excT                 exc,
  output psrPkg::modeT                excMode,
  output logic                        newFiqMask,
  output logic                        vectorTaken,
  output logic [psrPkg::psrWidth-1:0] vectorAddr
);
  import psrPkg::*;

  logic             undefReq;
  logic             swiReq;
  logic             prefetchReq;
  logic             dataAbortReq;
  logic             irqReq;
  logic             fiqReq;
  logic             undefOk;
  logic             swiOk;
  logic             prefetchOk;
  logic             dataAbortOk;
  logic             irqOk;
  logic             fiqOk;
  logic [modeMsb:0] curMode;

  assign {undefReq, swiReq, prefetchReq, dataAbortReq, irqReq, fiqReq} = exceptions;
  assign curMode = cpsr[modeMsb:0];

  // Masking and no re-entry into the mode already running
  assign dataAbortOk = dataAbortReq && (curMode != modeAbt);
  assign fiqOk       = fiqReq && !cpsr[bitF] && (curMode != modeFiq);
  assign irqOk       = irqReq && !cpsr[bitI] && (curMode != modeIrq);
  assign prefetchOk  = prefetchReq && (curMode != modeAbt);
  assign undefOk     = undefReq && (curMode != modeUnd);
  assign swiOk       = swiReq && (curMode != modeSvc);

  always_comb begin
    exc        = excNone;
    excMode    = modeT'(curMode); // Don't care when nothing is taken
    vectorAddr = '0;
    if (dataAbortOk) begin
      exc        = excDataAbort;
      excMode    = modeAbt;
      vectorAddr = vecDataAbort;
    end else if (fiqOk) begin
      exc        = excFastIrq;
      excMode    = modeFiq;
      vectorAddr = vecFiq;
    end else if (irqOk) begin
      exc        = excIrq;
      excMode    = modeIrq;
      vectorAddr = vecIrq;
    end else if (prefetchOk) begin
      exc        = excPrefetchAbort;
      excMode    = modeAbt;
      vectorAddr = vecPrefetch;
    end else if (undefOk) begin
      exc        = excUndefined;
      excMode    = modeUnd;
      vectorAddr = vecUndef;
    end else if (swiOk) begin
      exc        = excSoftwareIrq;
      excMode    = modeSvc;
      vectorAddr = vecSwi;
    end
  end

  assign newFiqMask  = (exc == excFastIrq); // F set only on FIQ entry
  assign vectorTaken = (exc != excNone);

endmodule

//--- rtl/msrMerge.sv
`timescale 1ns/100ps

module msrMerge (
  input  logic [4:0]                  mask,    // [4] SPSR, [3:0] f s x c
  input  logic [psrPkg::psrWidth-1:0] operand,
  input  logic [psrPkg::psrWidth-1:0] cpsr,
  input  logic [psrPkg::psrWidth-1:0] spsr,    // Current mode's SPSR
  output logic [psrPkg::psrWidth-1:0] msrValue,
  output logic                        msrValid
);
  import psrPkg::*;

  logic [psrWidth-1:0] target;
  logic [modeMsb:0]    curMode;
  logic                privileged;
  logic                hasSpsr;
  logic                spsrSel;
  logic                anyField;
  logic [modeMsb:0]    newMode;

  assign spsrSel  = mask[4];
  assign anyField = |mask[3:0];
  assign curMode  = cpsr[modeMsb:0];

  // Register being written supplies the untouched bytes
  assign target = spsrSel ? spsr : cpsr;

  assign privileged = (curMode != modeUsr);
  assign hasSpsr    = (curMode != modeUsr) && (curMode != modeSys);

  // Illegal mode value leaves the old mode in place
  assign newMode = isLegalMode(operand[modeMsb:0]) ? operand[modeMsb:0]
                                                   : target[modeMsb:0];

  always_comb begin
    msrValue = target;

    // Flags byte, open in every mode
    if (mask[3]) begin
      msrValue[31:24] = operand[31:24];
    end

    // Status and extension bytes need privilege
    if (mask[2] && privileged) begin
      msrValue[23:16] = operand[23:16];
    end
    if (mask[1] && privileged) begin
      msrValue[15:8] = operand[15:8];
    end

    // Control byte, masks and T plus the mode field
    if (mask[0] && privileged) begin
      msrValue[7:modeMsb+1] = operand[7:modeMsb+1];
      msrValue[modeMsb:0]   = newMode;
    end
  end

  // No fields selected means no MSR at all
  // SPSR target needs a mode that banks one
  assign msrValid = anyField && (!spsrSel || hasSpsr);

endmodule

//--- rtl/psrBank.sv
`timescale 1ns/100ps

module psrBank (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        advance,    // Commit this edge
  input  logic                        condPass,
  input  psrPkg::excT                 exc,
  input  psrPkg::modeT                excMode,
  input  logic                        newFiqMask,
  input  logic                        msrSpsr,    // MSR targets the SPSR
  input  logic                        msrValid,
  input  logic [psrPkg::psrWidth-1:0] msrValue,
  input  logic                        restore,
  input  logic                        flagsWrite,
  input  logic [3:0]                  flagsValue,
  output logic [psrPkg::psrWidth-1:0] cpsr,
  output logic [psrPkg::psrWidth-1:0] spsr
);
  import psrPkg::*;

  logic [numSpsr-1:0][psrWidth-1:0] spsrBank; // One slot per exception mode
  logic [modeMsb:0]                 curMode;
  logic                             curHasSpsr;
  bankIdxT                          curSlot;
  bankIdxT                          excSlot;
  logic [psrWidth-1:0]              excCpsr;
  logic                             restoreOk;

  function automatic bankIdxT slotOf(input logic [modeMsb:0] mode);
    case (mode)
      modeAbt: slotOf = bankAbt;
      modeUnd: slotOf = bankUnd;
      modeIrq: slotOf = bankIrq;
      modeFiq: slotOf = bankFiq;
      default: slotOf = bankSvc; // svc, usr and sys land here
    endcase
  endfunction

  assign curMode    = cpsr[modeMsb:0];
  assign curHasSpsr = (curMode != modeUsr) && (curMode != modeSys);
  assign curSlot    = slotOf(curMode);
  assign excSlot    = slotOf(excMode);

  // usr and sys have no SPSR and mirror the CPSR
  assign spsr = curHasSpsr ? spsrBank[curSlot] : cpsr;

  // Entry value keeps the flags and sets I, F and the mode
  always_comb begin
    excCpsr              = '0;
    excCpsr[bitN:bitV]   = cpsr[bitN:bitV];
    excCpsr[bitI]        = 1'b1;
    excCpsr[bitF]        = newFiqMask;
    excCpsr[modeMsb:0]   = excMode;
  end

  // An SPSR never written since reset holds mode zero and is skipped
  assign restoreOk = curHasSpsr && isLegalMode(spsr[modeMsb:0]);

  always_ff @(posedge clk) begin
    if (reset) begin
      cpsr     <= psrReset;
      spsrBank <= '0;
    end else if (advance) begin
      if (exc != excNone) begin        // Not gated by the condition
        spsrBank[excSlot] <= cpsr;
        cpsr              <= excCpsr;
      end else if (msrValid && condPass) begin
        if (msrSpsr) begin
          spsrBank[curSlot] <= msrValue;
        end else begin
          cpsr <= msrValue;
        end
      end else if (restore && condPass) begin
        if (restoreOk) begin
          cpsr <= spsr;
        end
      end else if (flagsWrite && condPass) begin
        cpsr[bitN:bitV] <= flagsValue;
      end
    end
  end

  // Mode field stays architected out of reset
  assert property (@(posedge clk) disable iff (reset)
    isLegalMode(cpsr[modeMsb:0]))
    else $error("illegal CPSR mode %b", cpsr[modeMsb:0]);

  // SPSR writes come only from exception entry or an MSR in a banked mode
  assert property (@(posedge clk) disable iff (reset)
    (spsrBank != $past(spsrBank)) |->
      ($past(reset) ||
       $past(advance && ((exc != excNone) ||
                         (condPass && msrValid && msrSpsr && curHasSpsr)))))
    else $error("SPSR bank changed without exception or MSR");

endmodule

//--- rtl/psrPkg.sv
package psrPkg;

  localparam int psrWidth = 32;
  localparam int numSpsr  = 5; // Banked SPSR slots

  // Flag and mask bit positions
  localparam int bitN    = 31;
  localparam int bitZ    = 30;
  localparam int bitC    = 29;
  localparam int bitV    = 28;
  localparam int bitI    = 7;  // IRQ disable
  localparam int bitF    = 6;  // FIQ disable
  localparam int modeMsb = 4;  // Mode field is [4:0]

  typedef enum logic [4:0] {
    modeUsr = 5'b10000,
    modeFiq = 5'b10001,
    modeIrq = 5'b10010,
    modeSvc = 5'b10011,
    modeAbt = 5'b10111,
    modeUnd = 5'b11011,
    modeSys = 5'b11111
  } modeT;

  // Order follows exception priority, highest first
  typedef enum logic [2:0] {
    excNone,
    excDataAbort,
    excFastIrq,
    excIrq,
    excPrefetchAbort,
    excUndefined,
    excSoftwareIrq
  } excT;

  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc,
    condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt,
    condGt, condLe, condAl, condNv
  } condT;

  typedef enum logic [2:0] {
    bankSvc = 3'd0,
    bankAbt = 3'd1,
    bankUnd = 3'd2,
    bankIrq = 3'd3,
    bankFiq = 3'd4
  } bankIdxT;

  // Supervisor, I and F set, flags clear
  localparam logic [psrWidth-1:0] psrReset = 32'h0000_00D3;

  localparam logic [psrWidth-1:0] vecDataAbort = 32'h0000_0010;
  localparam logic [psrWidth-1:0] vecFiq       = 32'h0000_001C;
  localparam logic [psrWidth-1:0] vecIrq       = 32'h0000_0018;
  localparam logic [psrWidth-1:0] vecPrefetch  = 32'h0000_000C;
  localparam logic [psrWidth-1:0] vecUndef     = 32'h0000_0004;
  localparam logic [psrWidth-1:0] vecSwi       = 32'h0000_0008;

  // True for the seven architected mode encodings
  function automatic logic isLegalMode(input logic [modeMsb:0] mode);
    case (mode)
      modeUsr, modeFiq, modeIrq, modeSvc,
      modeAbt, modeUnd, modeSys: isLegalMode = 1'b1;
      default:                   isLegalMode = 1'b0;
    endcase
  endfunction

endpackage

//--- rtl/statusUnit.sv
`timescale 1ns/100ps

module statusUnit (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        advance,
  input  psrPkg::condT                condCode,
  input  logic [3:0]                  flagsNext,
  input  logic                        flagsWrite,
  input  logic                        coprocFlags, // Flags from operand[31:28]
  input  logic [4:0]                  msrMask,
  input  logic [psrPkg::psrWidth-1:0] operand,
  input  logic                        restore,
  input  logic [5:0]                  exceptions,
  output logic [psrPkg::psrWidth-1:0] cpsr,
  output logic [psrPkg::psrWidth-1:0] spsr,
  output logic                        condPass,
  output logic                        vectorTaken,
  output logic [psrPkg::psrWidth-1:0] vectorAddr
);
  import psrPkg::*;

  excT                 exc;
  modeT                excMode;
  logic                newFiqMask;
  logic [psrWidth-1:0] msrValue;
  logic                msrValid;
  logic [3:0]          flagsValue;

  // Coprocessor transfers deliver flags on the operand
  assign flagsValue = coprocFlags ? operand[bitN:bitV] : flagsNext;

  condEval uCond (
    .cond  (condCode),
    .flags (cpsr[bitN:bitV]),
    .pass  (condPass)
  );

  exceptionPrioritizer uExc (
    .exceptions  (exceptions),
    .cpsr        (cpsr),
    .exc         (exc),
    .excMode     (excMode),
    .newFiqMask  (newFiqMask),
    .vectorTaken (vectorTaken),
    .vectorAddr  (vectorAddr)
  );

  msrMerge uMsr (
    .mask     (msrMask),
    .operand  (operand),
    .cpsr     (cpsr),
    .spsr     (spsr),
    .msrValue (msrValue),
    .msrValid (msrValid)
  );

  psrBank uBank (
    .clk        (clk),
    .reset      (reset),
    .advance    (advance),
    .condPass   (condPass),
    .exc        (exc),
    .excMode    (excMode),
    .newFiqMask (newFiqMask),
    .msrSpsr    (msrMask[4]),
    .msrValid   (msrValid),
    .msrValue   (msrValue),
    .restore    (restore),
    .flagsWrite (flagsWrite),
    .flagsValue (flagsValue),
    .cpsr       (cpsr),
    .spsr       (spsr)
  );

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the status unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f statusUnit.f \
  --top-module statusUnitTb -o statusUnitSim \
  && ./obj_dir/statusUnitSim | tee sim.log \
  || { echo "Build or simulation did not complete"; exit 1; }

grep -qx '\*\*\* PASSED \*\*\*' sim.log \
  && echo "Result: pass" \
  || { echo "Result: fail"; exit 1; }

//--- statusUnit.f
rtl/psrPkg.sv
rtl/condEval.sv
rtl/exceptionPrioritizer.sv
rtl/msrMerge.sv
rtl/psrBank.sv
rtl/statusUnit.sv
bench/statusChecker.sv
bench/statusUnitTb.sv
